// ==== hw/exe_cfg.svh ====
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath width
`define XLEN 32

// program counter width
`define PC_W 12

// register number width, 32 registers
`define REG_ADDR_W 5

// shift amount is the low bits of operand b
`define SHAMT_W 5

`endif

// ==== hw/exe_pkg.sv ====
`include "exe_cfg.svh"

package exe_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`PC_W-1:0] pc_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// alu_add is zero so a cleared register reads as a harmless add
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9,
		// passes operand b through
		alu_lui  = 4'd10
	} alu_op_e;

	// decoded control for one instruction
	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic wr_en;
		reg_addr_t rd;
	} dec_ctrl_t;

	// contents of the id/exe register
	typedef struct packed {
		pc_t pc;
		pc_t pc4;
		word_t inst;
		word_t fwd_opa;
		word_t fwd_opb;
		word_t imm;
		dec_ctrl_t ctrl;
	} id_exe_t;

endpackage

// ==== hw/id_decoder.sv ====
`timescale 1ns/1ps

`include "exe_cfg.svh"

module id_decoder import exe_pkg::*; (
	input word_t inst,
	output dec_ctrl_t ctrl,
	output word_t imm,
	output reg_addr_t rs1,
	output reg_addr_t rs2
);

	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rd;

	// instruction field decode
	logic is_r;
	logic f7_base;
	logic f7_alt;

	// per-instruction results before the bubble mux
	alu_op_e op;
	logic legal;
	logic use_imm;
	word_t imm_raw;

	assign opcode = inst[6:0];
	assign rd = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign funct7 = inst[31:25];

	assign is_r = (opcode == opc_op);
	assign f7_base = (funct7 == 7'b0000000);
	assign f7_alt = (funct7 == 7'b0100000);

	always_comb begin
		op = alu_add;
		legal = 1'b0;
		use_imm = 1'b0;
		imm_raw = '0;
		case (opcode)
			opc_op, opc_op_imm: begin
				use_imm = !is_r;
				imm_raw = {{(`XLEN-12){inst[31]}}, inst[31:20]};
				// funct7 only matters for r-type and for immediate shifts
				case (funct3)
					3'b000: begin
						op = (is_r && f7_alt) ? alu_sub : alu_add;
						legal = !is_r || f7_base || f7_alt;
					end
					3'b001: begin
						op = alu_sll;
						legal = f7_base;
					end
					3'b010: begin
						op = alu_slt;
						legal = !is_r || f7_base;
					end
					3'b011: begin
						op = alu_sltu;
						legal = !is_r || f7_base;
					end
					3'b100: begin
						op = alu_xor;
						legal = !is_r || f7_base;
					end
					3'b101: begin
						op = f7_alt ? alu_sra : alu_srl;
						legal = f7_base || f7_alt;
					end
					3'b110: begin
						op = alu_or;
						legal = !is_r || f7_base;
					end
					default: begin
						op = alu_and;
						legal = !is_r || f7_base;
					end
				endcase
			end
			opc_lui: begin
				op = alu_lui;
				legal = 1'b1;
				use_imm = 1'b1;
				imm_raw = {inst[31:12], 12'b0};
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	// illegal encodings become an all-zero bubble
	always_comb begin
		ctrl = '0;
		imm = '0;
		if (legal) begin
			ctrl.alu_op = op;
			ctrl.use_imm = use_imm;
			// x0 is never written
			ctrl.wr_en = (rd != '0);
			ctrl.rd = rd;
			imm = imm_raw;
		end
	end

endmodule

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward import exe_pkg::*; (
	input reg_addr_t rs1,
	input reg_addr_t rs2,
	input word_t rs1_data,
	input word_t rs2_data,

	// producer in execute, combinational result
	input reg_addr_t exe_rd,
	input logic exe_wr_en,
	input word_t exe_result,

	// producer in write-back, registered result
	input reg_addr_t wb_rd,
	input logic wb_wr_en,
	input word_t wb_result,

	output word_t opa,
	output word_t opb
);

	// newest producer wins, x0 always reads the register file
	function automatic word_t fwd_sel(
		input reg_addr_t rs,
		input word_t rf_data,
		input reg_addr_t e_rd,
		input logic e_wr,
		input word_t e_res,
		input reg_addr_t w_rd,
		input logic w_wr,
		input word_t w_res
	);
		if (rs == '0)
			return rf_data;
		else if (e_wr && (e_rd == rs))
			return e_res;
		else if (w_wr && (w_rd == rs))
			return w_res;
		return rf_data;
	endfunction

	assign opa = fwd_sel(rs1, rs1_data, exe_rd, exe_wr_en, exe_result,
		wb_rd, wb_wr_en, wb_result);
	assign opb = fwd_sel(rs2, rs2_data, exe_rd, exe_wr_en, exe_result,
		wb_rd, wb_wr_en, wb_result);

endmodule

// ==== hw/pipereg_id_exe.sv ====
`timescale 1ns/1ps

module pipereg_id_exe import exe_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic stall,
	input logic flush,
	input id_exe_t d,
	output id_exe_t q
);

	logic load;

	// advance only when enabled and not stalled
	assign load = en && !stall;

	// flush wins over stall and en, leaving a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

// ==== hw/exe_alu_stage.sv ====
`timescale 1ns/1ps

`include "exe_cfg.svh"

module exe_alu_stage import exe_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic stall,
	input id_exe_t ex,

	// combinational execute result, also sent back for forwarding
	output word_t exe_result,
	output reg_addr_t exe_rd,
	output logic exe_wr_en,

	// exe/wb register
	output word_t wb_result,
	output reg_addr_t wb_rd,
	output logic wb_wr_en,
	output pc_t wb_pc
);

	word_t opa;
	word_t opb;
	logic [`SHAMT_W-1:0] shamt;
	logic lt_signed;
	logic lt_unsigned;
	logic load;

	assign opa = ex.fwd_opa;
	assign opb = ex.ctrl.use_imm ? ex.imm : ex.fwd_opb;
	assign shamt = opb[`SHAMT_W-1:0];

	assign lt_signed = $signed(opa) < $signed(opb);
	assign lt_unsigned = opa < opb;

	always_comb begin
		case (ex.ctrl.alu_op)
			alu_add: exe_result = opa + opb;
			alu_sub: exe_result = opa - opb;
			alu_and: exe_result = opa & opb;
			alu_or: exe_result = opa | opb;
			alu_xor: exe_result = opa ^ opb;
			alu_sll: exe_result = opa << shamt;
			alu_srl: exe_result = opa >> shamt;
			alu_sra: exe_result = word_t'($signed(opa) >>> shamt);
			alu_slt: exe_result = {{(`XLEN-1){1'b0}}, lt_signed};
			alu_sltu: exe_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
			alu_lui: exe_result = opb;
			default: exe_result = '0;
		endcase
	end

	assign exe_rd = ex.ctrl.rd;
	assign exe_wr_en = ex.ctrl.wr_en;

	// holds together with id/exe so a stall never repeats a write
	assign load = en && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_result <= '0;
			wb_rd <= '0;
			wb_wr_en <= 1'b0;
			wb_pc <= '0;
		end else if (load) begin
			wb_result <= exe_result;
			wb_rd <= exe_rd;
			wb_wr_en <= exe_wr_en;
			wb_pc <= ex.pc;
		end
	end

endmodule

// ==== hw/exe_front_top.sv ====
`timescale 1ns/1ps

module exe_front_top import exe_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic stall,
	input logic flush,
	input word_t id_inst,
	input pc_t id_pc,
	input word_t rs1_data,
	input word_t rs2_data,
	output word_t wb_result,
	output reg_addr_t wb_rd,
	output logic wb_wr_en,
	output pc_t wb_pc
);

	dec_ctrl_t id_ctrl;
	word_t id_imm;
	reg_addr_t id_rs1;
	reg_addr_t id_rs2;
	word_t id_opa;
	word_t id_opb;
	pc_t id_pc4;

	id_exe_t id_exe_d;
	id_exe_t id_exe_q;

	// execute stage feedback for forwarding
	word_t exe_result;
	reg_addr_t exe_rd;
	logic exe_wr_en;

	assign id_pc4 = id_pc + pc_t'(4);

	id_decoder u_decoder (
		.inst(id_inst),
		.ctrl(id_ctrl),
		.imm(id_imm),
		.rs1(id_rs1),
		.rs2(id_rs2)
	);

	operand_forward u_forward (
		.rs1(id_rs1),
		.rs2(id_rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.exe_rd(exe_rd),
		.exe_wr_en(exe_wr_en),
		.exe_result(exe_result),
		.wb_rd(wb_rd),
		.wb_wr_en(wb_wr_en),
		.wb_result(wb_result),
		.opa(id_opa),
		.opb(id_opb)
	);

	// gather the decode side into one struct
	always_comb begin
		id_exe_d.pc = id_pc;
		id_exe_d.pc4 = id_pc4;
		id_exe_d.inst = id_inst;
		id_exe_d.fwd_opa = id_opa;
		id_exe_d.fwd_opb = id_opb;
		id_exe_d.imm = id_imm;
		id_exe_d.ctrl = id_ctrl;
	end

	pipereg_id_exe u_id_exe (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.stall(stall),
		.flush(flush),
		.d(id_exe_d),
		.q(id_exe_q)
	);

	exe_alu_stage u_exe (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.stall(stall),
		.ex(id_exe_q),
		.exe_result(exe_result),
		.exe_rd(exe_rd),
		.exe_wr_en(exe_wr_en),
		.wb_result(wb_result),
		.wb_rd(wb_rd),
		.wb_wr_en(wb_wr_en),
		.wb_pc(wb_pc)
	);

endmodule

// ==== verif/exe_front_sva.sv ====
`timescale 1ns/1ps

module exe_front_sva import exe_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic stall,
	input word_t wb_result,
	input reg_addr_t wb_rd,
	input logic wb_wr_en,
	input pc_t wb_pc
);

	// a write-back always names a real register
	a_wr_rd: assert property (@(posedge clk) disable iff (!arst_n)
		wb_wr_en |-> (wb_rd != '0))
		else $error("write-back enabled with rd x0");

	// frozen pipeline keeps the write-back outputs
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(stall || !en) |=> $stable({wb_result, wb_rd, wb_wr_en, wb_pc}))
		else $error("write-back outputs changed while the pipeline was held");

endmodule

bind exe_front_top exe_front_sva u_sva (
	.clk(clk),
	.arst_n(arst_n),
	.en(en),
	.stall(stall),
	.wb_result(wb_result),
	.wb_rd(wb_rd),
	.wb_wr_en(wb_wr_en),
	.wb_pc(wb_pc)
);

// ==== verif/exe_front_tb.sv ====
`timescale 1ns/1ps

module exe_front_tb import exe_pkg::*; ();

	localparam int num_dir = 10;
	localparam int num_rand = 160;
	localparam int reset_cycles = 16;
	localparam int clk_period = 4;
	localparam int timeout_ns = ((num_dir + num_rand) * 8 + reset_cycles + 8) * clk_period;

	// one expected write-back
	typedef struct packed {
		pc_t pc;
		reg_addr_t rd;
		word_t result;
		logic wr_en;
	} wb_exp_t;

	logic clk;
	logic arst_n;
	logic en;
	logic stall;
	logic flush;
	word_t id_inst;
	pc_t id_pc;
	word_t rs1_data;
	word_t rs2_data;
	word_t wb_result;
	reg_addr_t wb_rd;
	logic wb_wr_en;
	pc_t wb_pc;

	word_t arch_rf [32];
	word_t lag_rf [32];
	wb_exp_t exp_q [$];
	string name_q [$];
	word_t prog [$];
	string test_name;
	int seed;
	logic adv_prev;

	exe_front_top u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.stall(stall),
		.flush(flush),
		.id_inst(id_inst),
		.id_pc(id_pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wb_result(wb_result),
		.wb_rd(wb_rd),
		.wb_wr_en(wb_wr_en),
		.wb_pc(wb_pc)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input int rs1,
		input logic [2:0] f3, input int rd);
		return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input int rd);
		return {imm, 5'(rd), 7'b0110111};
	endfunction

	// legal encodings per the RV32I tables for OP, OP-IMM and LUI
	function automatic logic inst_legal(input word_t inst);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = inst[14:12];
		f7 = inst[31:25];
		case (inst[6:0])
			7'b0110111: return 1'b1;
			7'b0110011: return (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			7'b0010011: begin
				if (f3 == 3'd1)
					return f7 == 7'h00;
				if (f3 == 3'd5)
					return (f7 == 7'h00) || (f7 == 7'h20);
				return 1'b1;
			end
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t alu_ref(input word_t inst, input word_t a, input word_t rs2v);
		word_t b;
		logic [4:0] sh;
		logic alt;
		alt = (inst[31:25] == 7'h20);
		if (inst[6:0] == 7'b0110111)
			return {inst[31:12], 12'h000};
		b = (inst[6:0] == 7'b0010011) ? {{20{inst[31]}}, inst[31:20]} : rs2v;
		sh = b[4:0];
		case (inst[14:12])
			3'd0: return (inst[6:0] == 7'b0110011 && alt) ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> sh) : a >> sh;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// small register set so dependencies show up often
	function automatic word_t rand_inst();
		int kind;
		logic [2:0] f3;
		logic [11:0] imm;
		logic pick;
		kind = {$random(seed)} % 16;
		f3 = 3'($random(seed));
		imm = 12'($random(seed));
		pick = 1'($random(seed));
		if (kind < 6)
			return enc_r((pick && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00,
				{$random(seed)} % 8, {$random(seed)} % 8, f3, {$random(seed)} % 8);
		if (kind < 11) begin
			if (f3 == 3'd1)
				imm[11:5] = 7'h00;
			if (f3 == 3'd5)
				imm[11:5] = pick ? 7'h20 : 7'h00;
			return enc_i(imm, {$random(seed)} % 8, f3, {$random(seed)} % 8);
		end
		if (kind < 13)
			return enc_u(20'($random(seed)), {$random(seed)} % 8);
		if (kind == 13)
			return enc_i(imm, {$random(seed)} % 8, 3'd0, 0);
		if (kind == 14)
			return {$random(seed)} & 32'hffff_ff80 | 32'h0000_0003;
		return enc_r(7'h00, {$random(seed)} % 8, {$random(seed)} % 8, f3, 0);
	endfunction

	task automatic issue(input word_t inst, input pc_t pc);
		wb_exp_t e;
		logic legal;
		legal = inst_legal(inst);
		e.pc = pc;
		e.rd = legal ? inst[11:7] : '0;
		e.result = alu_ref(inst, arch_rf[inst[19:15]], arch_rf[inst[24:20]]);
		e.wr_en = legal && (inst[11:7] != 0);
		if (e.wr_en)
			arch_rf[inst[11:7]] = e.result;
		exp_q.push_back(e);
		name_q.push_back(test_name);
	endtask

	task automatic check_idle(input string phase);
		assert (wb_result == '0 && wb_rd == '0 && !wb_wr_en && wb_pc == '0) else begin
			$display("Fail %s: expected all outputs 0, actual result=%h rd=%0d wr_en=%b pc=%h",
				phase, wb_result, wb_rd, wb_wr_en, wb_pc);
			$display("TEST FAILED");
			$fatal(1, "outputs not idle");
		end
	endtask

	task automatic check_val(input string name, input string field, input word_t exp_v,
		input word_t act_v);
		assert (exp_v === act_v) else begin
			$display("Fail %s %s: expected %h, actual %h", name, field, exp_v, act_v);
			$display("TEST FAILED");
			$fatal(1, "write-back mismatch");
		end
	endtask

	task automatic compare_wb();
		wb_exp_t e;
		string name;
		// flushed slots and idle cycles carry pc 0
		if (!wb_wr_en && wb_pc == '0)
			return;
		assert (exp_q.size() > 0) else begin
			$display("unexpected write-back at pc %h with nothing pending", wb_pc);
			$display("TEST FAILED");
			$fatal(1, "extra write-back");
		end
		e = exp_q.pop_front();
		name = name_q.pop_front();
		check_val(name, "pc", word_t'(e.pc), word_t'(wb_pc));
		check_val(name, "rd", word_t'(e.rd), word_t'(wb_rd));
		check_val(name, "wr_en", word_t'(e.wr_en), word_t'(wb_wr_en));
		if (e.wr_en)
			check_val(name, "result", e.result, wb_result);
	endtask

	// outputs read before the edge updates them
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			adv_prev = 1'b0;
		end else begin
			if (wb_wr_en)
				lag_rf[wb_rd] = wb_result;
			if (adv_prev)
				compare_wb();
			adv_prev = en && !stall;
		end
	end

	initial begin
		#(timeout_ns * 1ns);
		$display("watchdog expired with %0d results pending", exp_q.size());
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		word_t inst;
		pc_t pc;
		int idx;
		int r;
		clk = 1'b0;
		arst_n = 1'b0;
		en = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		id_inst = '0;
		id_pc = '0;
		rs1_data = '0;
		rs2_data = '0;
		seed = 60;
		test_name = "reset";
		for (int i = 0; i < 32; i++) begin
			arch_rf[i] = '0;
			lag_rf[i] = '0;
		end

		// dependency chains at distance 1 and 2, x0 writes
		prog.push_back(enc_i(12'd5, 0, 3'd0, 1));
		prog.push_back(enc_i(-12'sd3, 1, 3'd0, 2));
		prog.push_back(enc_r(7'h00, 2, 1, 3'd0, 3));
		prog.push_back(enc_r(7'h20, 1, 3, 3'd0, 4));
		prog.push_back(enc_i(12'd9, 4, 3'd0, 0));
		prog.push_back(enc_r(7'h00, 4, 0, 3'd0, 5));
		prog.push_back(enc_u(20'habcde, 6));
		prog.push_back(enc_i(12'h404, 6, 3'd5, 7));
		prog.push_back(enc_r(7'h00, 7, 0, 3'd3, 1));
		prog.push_back(enc_r(7'h00, 1, 7, 3'd2, 2));
		for (int i = 0; i < num_rand; i++)
			prog.push_back(rand_inst());

		repeat (reset_cycles) begin
			@(negedge clk);
			check_idle("reset");
		end
		arst_n = 1'b1;
		en = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_idle("after reset");
		end

		idx = 0;
		pc = 12'h100;
		while (idx < prog.size()) begin
			@(negedge clk);
			inst = prog[idx];
			test_name = (idx < num_dir) ? "directed" : "random";
			r = {$random(seed)} % 16;
			en = (r != 0);
			stall = (r == 1) || (r == 2);
			flush = (r == 3);
			id_inst = inst;
			id_pc = pc;
			rs1_data = lag_rf[inst[19:15]];
			rs2_data = lag_rf[inst[24:20]];
			if (en && !stall) begin
				// a flushed instruction never reaches write-back
				if (!flush)
					issue(inst, pc);
				idx++;
				pc = pc + 12'd4;
			end
		end

		@(negedge clk);
		en = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		id_inst = '0;
		id_pc = '0;
		rs1_data = '0;
		rs2_data = '0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/exe_pkg.sv
hw/id_decoder.sv
hw/operand_forward.sv
hw/pipereg_id_exe.sv
hw/exe_alu_stage.sv
hw/exe_front_top.sv
verif/exe_front_sva.sv
verif/exe_front_tb.sv
